// File: logic/chip_pkg.sv
package chip_pkg;

  localparam int NUM_CH        = 4;
  localparam int NUM_REQ       = NUM_CH + 1;  // channels first, then the CPU
  localparam int CPU_REQ       = NUM_CH;
  localparam int RING_WORDS    = 32;
  localparam int ADDR_BITS     = 8;
  localparam int RAM_WORDS     = 1 << ADDR_BITS;
  localparam int QUEUE_DEPTH   = 4;
  localparam int RST_HOLD_BITS = 4;

  typedef logic [31:0]                    word_t;
  typedef logic [ADDR_BITS-1:0]           lsab_addr_t;
  typedef logic [$clog2(RING_WORDS)-1:0]  ring_ptr_t;
  typedef logic [$clog2(NUM_CH)-1:0]      ch_id_t;
  typedef logic [$clog2(NUM_REQ)-1:0]     req_idx_t;

  // one access offered to the arbiter
  typedef struct packed {
    logic       valid;
    logic       write;
    lsab_addr_t address;
    word_t      wdata;
  } mem_req_t;

  typedef struct packed {
    logic  grant;   // combinational, same cycle as valid
    logic  rvalid;  // one cycle after a granted read
    word_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    ring_ptr_t in_wptr;
    ring_ptr_t out_rptr;
  } chan_status_t;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GRANT,
    WAIT_DATA
  } cpu_state_e;

endpackage

// File: logic/lsab_ram.sv
module lsab_ram (
  input  logic               CPU_CLK,
  input  logic               en,
  input  logic               we,
  input  chip_pkg::lsab_addr_t addr,
  input  chip_pkg::word_t    wdata,
  output chip_pkg::word_t    rdata
);
  import chip_pkg::*;

  word_t mem [RAM_WORDS];

  // one access per cycle, read data appears on the following cycle
  always_ff @(posedge CPU_CLK) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

// File: logic/lsab_arbiter.sv
module lsab_arbiter (
  input  logic               CPU_CLK,
  input  logic               RST,
  input  chip_pkg::mem_req_t req [chip_pkg::NUM_REQ],
  output chip_pkg::mem_rsp_t rsp [chip_pkg::NUM_REQ]
);
  import chip_pkg::*;

  req_idx_t   last_grant;
  req_idx_t   gnt_idx;
  logic       gnt_any;
  logic       rd_pending;
  req_idx_t   rd_owner;
  word_t      ram_rdata;

  // search starts one past the requester granted last
  always_comb begin
    int idx;
    gnt_idx = last_grant;
    gnt_any = 1'b0;
    for (int k = 1; k <= NUM_REQ; k++) begin
      idx = int'(last_grant) + k;
      if (idx >= NUM_REQ) begin
        idx = idx - NUM_REQ;
      end
      if (!gnt_any && req[idx].valid) begin
        gnt_any = 1'b1;
        gnt_idx = req_idx_t'(idx);
      end
    end
  end

  lsab_ram u_ram (
    .CPU_CLK (CPU_CLK),
    .en      (gnt_any),
    .we      (req[gnt_idx].write),
    .addr    (req[gnt_idx].address),
    .wdata   (req[gnt_idx].wdata),
    .rdata   (ram_rdata)
  );

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      last_grant <= req_idx_t'(NUM_REQ - 1);  // so channel 0 wins first
      rd_pending <= 1'b0;
    end else begin
      if (gnt_any) begin
        last_grant <= gnt_idx;
      end
      rd_pending <= gnt_any && !req[gnt_idx].write;
    end
  end

  // owner of the read that is in flight in the RAM
  always_ff @(posedge CPU_CLK) begin
    if (gnt_any && !req[gnt_idx].write) begin
      rd_owner <= gnt_idx;
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      rsp[i].grant  = gnt_any && (gnt_idx == req_idx_t'(i));
      rsp[i].rvalid = rd_pending && (rd_owner == req_idx_t'(i));
      rsp[i].rdata  = ram_rdata;  // only meaningful alongside rvalid
    end
  end

endmodule

// File: logic/channel_port.sv
module channel_port (
  input  logic                   CPU_CLK,
  input  logic                   RST,
  input  chip_pkg::ch_id_t       id,
  input  logic                   write,
  input  logic                   read,
  input  logic                   errack,
  input  chip_pkg::word_t        wdata,
  output chip_pkg::word_t        rdata,
  output logic                   rvalid,
  output logic                   irq,
  output logic                   err,
  output chip_pkg::chan_status_t status,
  output chip_pkg::mem_req_t     mem_req,
  input  chip_pkg::mem_rsp_t     mem_rsp
);
  import chip_pkg::*;

  localparam int QP_BITS = $clog2(QUEUE_DEPTH);

  // inbound queue between the peripheral and the arbiter
  word_t              q_mem [QUEUE_DEPTH];
  logic [QP_BITS-1:0] q_wr;
  logic [QP_BITS-1:0] q_rd;
  logic [QP_BITS:0]   q_cnt;
  logic               q_full;
  logic               q_empty;
  logic               push;
  logic               overflow;

  ring_ptr_t          in_ptr;
  ring_ptr_t          out_ptr;

  logic               fetch_want;   // read strobe seen, request not yet granted
  logic               fetch_wait;   // read granted, data not yet back
  logic               fetch_busy;
  logic               dbl_read;

  logic               hold_q;
  logic               hold_fetch;
  logic               use_fetch;
  logic               granted;
  logic               fetch_gnt;
  logic               wr_gnt;

  assign q_full   = (q_cnt == (QP_BITS + 1)'(QUEUE_DEPTH));
  assign q_empty  = (q_cnt == '0);
  assign push     = write && !q_full;
  assign overflow = write && q_full;   // the word is lost

  assign fetch_busy = fetch_want || fetch_wait;
  assign dbl_read   = read && fetch_busy;

  // an ungranted request stays as it was, else the fetch goes ahead of the queue
  assign use_fetch = hold_q ? hold_fetch : fetch_want;

  always_comb begin
    mem_req.valid = use_fetch || !q_empty;
    mem_req.write = !use_fetch;
    if (use_fetch) begin
      mem_req.address = {id, 1'b1, out_ptr};  // outbound half of the region
      mem_req.wdata   = '0;
    end else begin
      mem_req.address = {id, 1'b0, in_ptr};
      mem_req.wdata   = q_mem[q_rd];
    end
  end

  assign granted   = mem_req.valid && mem_rsp.grant;
  assign fetch_gnt = granted && use_fetch;
  assign wr_gnt    = granted && !use_fetch;

  always_ff @(posedge CPU_CLK) begin
    if (push) begin
      q_mem[q_wr] <= wdata;
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      q_wr       <= '0;
      q_rd       <= '0;
      q_cnt      <= '0;
      in_ptr     <= '0;
      irq        <= 1'b0;
      hold_q     <= 1'b0;
      hold_fetch <= 1'b0;
    end else begin
      if (push) begin
        q_wr <= q_wr + 1'b1;
      end
      if (wr_gnt) begin
        q_rd   <= q_rd + 1'b1;
        in_ptr <= in_ptr + 1'b1;
      end
      if (push && !wr_gnt) begin
        q_cnt <= q_cnt + 1'b1;
      end else if (!push && wr_gnt) begin
        q_cnt <= q_cnt - 1'b1;
      end
      irq        <= wr_gnt;  // one pulse per word landed
      hold_q     <= mem_req.valid && !mem_rsp.grant;
      hold_fetch <= use_fetch;
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      fetch_want <= 1'b0;
      fetch_wait <= 1'b0;
      out_ptr    <= '0;
      rvalid     <= 1'b0;
    end else begin
      if (read && !fetch_busy) begin
        fetch_want <= 1'b1;
      end
      if (fetch_gnt) begin
        fetch_want <= 1'b0;
        fetch_wait <= 1'b1;
        out_ptr    <= out_ptr + 1'b1;
      end
      if (mem_rsp.rvalid) begin
        fetch_wait <= 1'b0;
      end
      rvalid <= mem_rsp.rvalid;  // the arbiter only answers the reads we made
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (mem_rsp.rvalid) begin
      rdata <= mem_rsp.rdata;
    end
  end

  // a new error in the same cycle as errack keeps the flag up
  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      err <= 1'b0;
    end else begin
      if (errack) begin
        err <= 1'b0;
      end
      if (overflow || dbl_read) begin
        err <= 1'b1;
      end
    end
  end

  assign status.in_wptr  = in_ptr;
  assign status.out_rptr = out_ptr;

endmodule

// File: logic/cpu_port.sv
module cpu_port (
  input  logic                 CPU_CLK,
  input  logic                 RST,
  input  logic                 req,
  input  logic                 write,
  input  chip_pkg::lsab_addr_t addr,
  input  chip_pkg::word_t      wdata,
  output chip_pkg::word_t      rdata,
  output logic                 rvalid,
  output logic                 busy,
  output chip_pkg::mem_req_t   mem_req,
  input  chip_pkg::mem_rsp_t   mem_rsp
);
  import chip_pkg::*;

  cpu_state_e state;
  logic       acc_write;
  lsab_addr_t acc_addr;
  word_t      acc_wdata;

  assign busy = (state != IDLE);

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      state  <= IDLE;
      rvalid <= 1'b0;
    end else begin
      rvalid <= 1'b0;
      case (state)
        IDLE: begin
          if (req) begin
            state <= WAIT_GRANT;
          end
        end
        WAIT_GRANT: begin
          if (mem_rsp.grant) begin
            state <= acc_write ? IDLE : WAIT_DATA;  // a write is done at its grant edge
          end
        end
        WAIT_DATA: begin
          if (mem_rsp.rvalid) begin
            state  <= IDLE;
            rvalid <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // the access is captured once and held until it completes
  always_ff @(posedge CPU_CLK) begin
    if (state == IDLE && req) begin
      acc_write <= write;
      acc_addr  <= addr;
      acc_wdata <= wdata;
    end
    if (state == WAIT_DATA && mem_rsp.rvalid) begin
      rdata <= mem_rsp.rdata;
    end
  end

  assign mem_req.valid   = (state == WAIT_GRANT);
  assign mem_req.write   = acc_write;
  assign mem_req.address = acc_addr;
  assign mem_req.wdata   = acc_wdata;

endmodule

// File: logic/chip.sv
module chip (
  input  logic                   CPU_CLK,
  input  logic                   RST,
  input  logic                   ch_write  [chip_pkg::NUM_CH],
  input  chip_pkg::word_t        ch_wdata  [chip_pkg::NUM_CH],
  input  logic                   ch_read   [chip_pkg::NUM_CH],
  input  logic                   ch_errack [chip_pkg::NUM_CH],
  output chip_pkg::word_t        ch_rdata  [chip_pkg::NUM_CH],
  output logic                   ch_rvalid [chip_pkg::NUM_CH],
  output logic                   ch_irq    [chip_pkg::NUM_CH],
  output logic                   ch_err    [chip_pkg::NUM_CH],
  output chip_pkg::chan_status_t ch_status [chip_pkg::NUM_CH],
  input  logic                   cpu_req,
  input  logic                   cpu_write,
  input  chip_pkg::lsab_addr_t   cpu_addr,
  input  chip_pkg::word_t        cpu_wdata,
  output chip_pkg::word_t        cpu_rdata,
  output logic                   cpu_rvalid,
  output logic                   cpu_busy,
  output logic                   cpu_ready
);
  import chip_pkg::*;

  logic [RST_HOLD_BITS-1:0] rst_cnt;
  logic                     cpu_rst;
  mem_req_t                 mem_req [NUM_REQ];
  mem_rsp_t                 mem_rsp [NUM_REQ];

  // the CPU comes out of reset once the counter reaches its top bit
  assign cpu_ready = rst_cnt[RST_HOLD_BITS-1];
  assign cpu_rst   = RST && cpu_ready;  // active low like RST

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      rst_cnt <= '0;
    end else if (!cpu_ready) begin
      rst_cnt <= rst_cnt + 1'b1;
    end
  end

  for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
    channel_port u_ch (
      .CPU_CLK (CPU_CLK),
      .RST     (RST),
      .id      (ch_id_t'(c)),
      .write   (ch_write[c]),
      .read    (ch_read[c]),
      .errack  (ch_errack[c]),
      .wdata   (ch_wdata[c]),
      .rdata   (ch_rdata[c]),
      .rvalid  (ch_rvalid[c]),
      .irq     (ch_irq[c]),
      .err     (ch_err[c]),
      .status  (ch_status[c]),
      .mem_req (mem_req[c]),
      .mem_rsp (mem_rsp[c])
    );
  end

  cpu_port u_cpu (
    .CPU_CLK (CPU_CLK),
    .RST     (cpu_rst),
    .req     (cpu_req),
    .write   (cpu_write),
    .addr    (cpu_addr),
    .wdata   (cpu_wdata),
    .rdata   (cpu_rdata),
    .rvalid  (cpu_rvalid),
    .busy    (cpu_busy),
    .mem_req (mem_req[CPU_REQ]),
    .mem_rsp (mem_rsp[CPU_REQ])
  );

  lsab_arbiter u_arb (
    .CPU_CLK (CPU_CLK),
    .RST     (RST),
    .req     (mem_req),
    .rsp     (mem_rsp)
  );

endmodule

// File: tb/clock_gen.sv
module clock_gen (
  output logic CPU_CLK,
  output logic RST
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    CPU_CLK = 1'b0;
    forever #5 CPU_CLK = ~CPU_CLK;
  end

  // reset held low over the first two rising edges
  initial begin
    RST = 1'b0;
    repeat (2) @(posedge CPU_CLK);
    RST <= 1'b1;
  end

endmodule

// File: tb/chip_sva.sv
module chip_sva (
  input logic                 CPU_CLK,
  input logic                 RST,
  input chip_pkg::mem_req_t   mem_req   [chip_pkg::NUM_REQ],
  input chip_pkg::mem_rsp_t   mem_rsp   [chip_pkg::NUM_REQ],
  input logic                 ch_irq    [chip_pkg::NUM_CH],
  input logic                 ch_err    [chip_pkg::NUM_CH],
  input logic                 ch_errack [chip_pkg::NUM_CH],
  input logic                 cpu_req,
  input logic                 cpu_busy,
  input chip_pkg::lsab_addr_t cpu_acc_addr
);
  timeunit 1ns;
  timeprecision 100ps;
  import chip_pkg::*;

  logic [NUM_REQ-1:0] grants;
  logic [NUM_REQ-1:0] valids;

  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      grants[i] = mem_rsp[i].grant;
      valids[i] = mem_req[i].valid;
    end
  end

  // exactly one requester that asks gets the grant whenever any asks
  a_grant_onehot: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $onehot0(grants) && ((grants & ~valids) == '0) && ((|grants) == (|valids)))
    else $error("grant is not one-hot to a valid requester");

  for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
    a_err_hold: assert property (@(posedge CPU_CLK) disable iff (!RST)
      ch_err[c] && !ch_errack[c] |=> ch_err[c])
      else $error("err dropped without errack on channel %0d", c);
    // each irq cycle follows exactly one landed word
    a_irq_pulse: assert property (@(posedge CPU_CLK) disable iff (!RST)
      ch_irq[c] |-> $past(mem_req[c].valid && mem_req[c].write && mem_rsp[c].grant))
      else $error("irq without a landed word on channel %0d", c);
  end

  a_busy_block: assert property (@(posedge CPU_CLK) disable iff (!RST)
    cpu_busy && cpu_req |=> $stable(cpu_acc_addr))
    else $error("cpu request taken while busy");

endmodule

bind chip chip_sva u_sva (
  .CPU_CLK      (CPU_CLK),
  .RST          (RST),
  .mem_req      (mem_req),
  .mem_rsp      (mem_rsp),
  .ch_irq       (ch_irq),
  .ch_err       (ch_err),
  .ch_errack    (ch_errack),
  .cpu_req      (cpu_req),
  .cpu_busy     (cpu_busy),
  .cpu_acc_addr (u_cpu.acc_addr)
);

// File: tb/chip_tb.sv
module chip_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import chip_pkg::*;

  localparam int TRANSFERS   = 4 * 36 + 4 * 32 + 4 * 72 + 4 * 24 + 150;
  localparam int WATCHDOG_NS = TRANSFERS * 30 * 10;

  logic         CPU_CLK, RST;
  logic         ch_write [NUM_CH];
  word_t        ch_wdata [NUM_CH];
  logic         ch_read [NUM_CH];
  logic         ch_errack [NUM_CH];
  word_t        ch_rdata [NUM_CH];
  logic         ch_rvalid [NUM_CH];
  logic         ch_irq [NUM_CH];
  logic         ch_err [NUM_CH];
  chan_status_t ch_status [NUM_CH];
  logic         cpu_req, cpu_write, cpu_rvalid, cpu_busy, cpu_ready;
  lsab_addr_t   cpu_addr;
  word_t        cpu_wdata, cpu_rdata;

  // model of the RAM and of every ring pointer
  word_t model_mem [RAM_WORDS];
  bit    model_known [RAM_WORDS];
  word_t in_acc [NUM_CH][$];   // accepted words not landed yet
  word_t ch_exp [NUM_CH][$];
  word_t strobed [NUM_CH][$];
  word_t cpu_exp [$];
  bit    cpu_chk [$];
  int    landed [NUM_CH];
  int    out_wr [NUM_CH];
  int    out_rd [NUM_CH];
  bit    track_in = 1'b1;
  bit    allow_err = 1'b0;
  int    errors = 0;
  int    checks = 0;
  word_t seed = 2;

  clock_gen u_clk (.CPU_CLK(CPU_CLK), .RST(RST));

  chip UUT (.*);

  function automatic word_t lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // region rule, 64 words per channel with the outbound ring in the upper half
  function automatic lsab_addr_t ring_addr(int c, bit outbound, int idx);
    return lsab_addr_t'(c * 64 + (outbound ? 32 : 0) + idx % RING_WORDS);
  endfunction

  function automatic word_t expected_word(lsab_addr_t a);
    return model_mem[a];
  endfunction

  // true while a queued word is still on its way to this inbound slot
  function automatic bit slot_pending(lsab_addr_t a);
    int c;
    int off;
    c = int'(a) / 64;
    if (int'(a) % 64 >= 32) return 1'b0;
    off = (int'(a) % 64 - landed[c] % 32 + 32) % 32;
    return off < in_acc[c].size();
  endfunction

  task automatic check_value(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic note_error(string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic end_test(string name, int err_before);
    $display("test %s finished with %0d errors", name, errors - err_before);
  endtask

  // called on a rising edge with cpu_busy low
  task automatic cpu_access(bit wr, lsab_addr_t a, word_t d, bit chk, output word_t rd);
    cpu_req   <= 1'b1;
    cpu_write <= wr;
    cpu_addr  <= a;
    cpu_wdata <= d;
    if (!wr) begin
      cpu_exp.push_back(expected_word(a));
      cpu_chk.push_back(chk);
    end
    @(posedge CPU_CLK);
    cpu_addr <= ~a;  // the request stays up one more cycle while busy and must be ignored
    @(posedge CPU_CLK);
    cpu_req <= 1'b0;
    while (cpu_busy) @(posedge CPU_CLK);
    rd = cpu_rdata;
    if (wr) begin
      model_mem[a]   = d;
      model_known[a] = 1'b1;
    end
  endtask

  task automatic out_fill(int c, int n);
    word_t rd;
    for (int k = 0; k < n; k++) begin
      cpu_access(1'b1, ring_addr(c, 1'b1, out_wr[c]), lcg_next(), 1'b0, rd);
      out_wr[c]++;
    end
  endtask

  task automatic out_drain(int c, int n);
    for (int k = 0; k < n; k++) begin
      ch_read[c] <= 1'b1;
      ch_exp[c].push_back(expected_word(ring_addr(c, 1'b1, out_rd[c])));
      out_rd[c]++;
      @(posedge CPU_CLK);
      ch_read[c] <= 1'b0;
      while (!ch_rvalid[c]) @(posedge CPU_CLK);
    end
  endtask

  // compare process, values sampled at the rising edge
  always @(posedge CPU_CLK) begin
    lsab_addr_t a;
    if (RST) begin
      if (cpu_rvalid) begin
        if (cpu_exp.size() == 0) begin
          note_error("cpu_rvalid with no read outstanding");
        end else if (cpu_chk.pop_front()) begin
          check_value("cpu_rdata", cpu_rdata, cpu_exp.pop_front());
        end else begin
          void'(cpu_exp.pop_front());
        end
      end
      for (int c = 0; c < NUM_CH; c++) begin
        if (ch_rvalid[c]) begin
          if (ch_exp[c].size() == 0) begin
            note_error($sformatf("rvalid on channel %0d with no read strobed", c));
          end else begin
            check_value($sformatf("ch_rdata[%0d]", c), ch_rdata[c], ch_exp[c].pop_front());
          end
        end
        if (ch_irq[c]) begin
          check_value($sformatf("ch_status[%0d].in_wptr", c),
                      word_t'(ch_status[c].in_wptr), word_t'((landed[c] + 1) % RING_WORDS));
          if (track_in && in_acc[c].size() == 0) begin
            note_error($sformatf("irq on channel %0d with no word queued", c));
          end else if (track_in) begin
            a = ring_addr(c, 1'b0, landed[c]);
            model_mem[a]   = in_acc[c].pop_front();
            model_known[a] = 1'b1;
          end
          landed[c]++;
        end
        if (ch_err[c] && !allow_err) begin
          note_error($sformatf("err raised on channel %0d", c));
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int    n;
    int    e0;
    int    j;
    int    quiet;
    int    base [NUM_CH];
    word_t w;
    word_t rd;
    lsab_addr_t a;

    for (int c = 0; c < NUM_CH; c++) begin
      ch_write[c]  = 1'b0;
      ch_wdata[c]  = '0;
      ch_read[c]   = 1'b0;
      ch_errack[c] = 1'b0;
    end
    cpu_req   = 1'b0;
    cpu_write = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;

    // test 1, reset and the CPU reset stretch
    e0 = errors;
    wait (RST);
    n = 0;
    while (!cpu_ready && n < 20) begin
      @(posedge CPU_CLK);
      n++;
      cpu_req   <= (n < 5);  // early requests must be ignored
      cpu_write <= 1'b1;
      if (cpu_busy) note_error("cpu_busy rose while the CPU was held in reset");
    end
    check_value("cpu_ready delay", word_t'(n - 1), 32'd8);
    repeat (2) @(posedge CPU_CLK);
    if (cpu_busy || cpu_rvalid) note_error("cpu port active after reset");
    for (int c = 0; c < NUM_CH; c++) begin
      if (ch_irq[c] || ch_err[c] || ch_rvalid[c]) note_error("channel output high after reset");
      check_value($sformatf("ch_status[%0d]", c), word_t'(ch_status[c]), '0);
    end
    end_test("reset", e0);

    // test 2, inbound words on all channels, across the ring wrap
    e0 = errors;
    for (int k = 0; k < 36; k++) begin
      for (int c = 0; c < NUM_CH; c++) begin
        w = lcg_next();
        ch_write[c] <= 1'b1;
        ch_wdata[c] <= w;
        in_acc[c].push_back(w);
      end
      @(posedge CPU_CLK);
      for (int c = 0; c < NUM_CH; c++) ch_write[c] <= 1'b0;
      repeat (8) @(posedge CPU_CLK);
    end
    for (int c = 0; c < NUM_CH; c++) begin
      while (in_acc[c].size() != 0) @(posedge CPU_CLK);
      check_value($sformatf("irq count %0d", c), word_t'(landed[c]), 32'd36);
      for (int k = 0; k < RING_WORDS; k++) begin
        cpu_access(1'b0, ring_addr(c, 1'b0, k), '0, 1'b1, rd);
      end
    end
    end_test("inbound", e0);

    // test 3, outbound words written by the CPU and drained by the peripheral
    e0 = errors;
    for (int c = 0; c < NUM_CH; c++) begin
      out_fill(c, 20);
      out_drain(c, 20);
      out_fill(c, 16);
      out_drain(c, 16);
      @(posedge CPU_CLK);
      check_value($sformatf("ch_status[%0d].out_rptr", c),
                  word_t'(ch_status[c].out_rptr), word_t'(out_rd[c] % RING_WORDS));
    end
    end_test("outbound", e0);

    // test 4, every channel strobes on every cycle and overflows its queue
    e0 = errors;
    track_in  = 1'b0;
    allow_err = 1'b1;
    for (int c = 0; c < NUM_CH; c++) base[c] = landed[c];
    repeat (12) begin
      for (int c = 0; c < NUM_CH; c++) begin
        w = lcg_next();
        ch_write[c] <= 1'b1;
        ch_wdata[c] <= w;
        strobed[c].push_back(w);
      end
      @(posedge CPU_CLK);
    end
    for (int c = 0; c < NUM_CH; c++) ch_write[c] <= 1'b0;
    quiet = 0;
    while (quiet < 8) begin
      @(posedge CPU_CLK);
      quiet = (ch_irq[0] || ch_irq[1] || ch_irq[2] || ch_irq[3]) ? 0 : quiet + 1;
    end
    for (int c = 0; c < NUM_CH; c++) begin
      if (!ch_err[c]) note_error($sformatf("err did not set on overflow of channel %0d", c));
      ch_errack[c] <= 1'b1;
    end
    @(posedge CPU_CLK);
    for (int c = 0; c < NUM_CH; c++) ch_errack[c] <= 1'b0;
    @(posedge CPU_CLK);
    for (int c = 0; c < NUM_CH; c++) begin
      if (ch_err[c]) note_error($sformatf("err still set after errack on channel %0d", c));
    end
    allow_err = 1'b0;
    for (int c = 0; c < NUM_CH; c++) begin
      n = landed[c] - base[c];
      if (n == 0 || n >= 12) note_error($sformatf("channel %0d kept %0d of 12 words", c, n));
      check_value($sformatf("ch_status[%0d].in_wptr", c),
                  word_t'(ch_status[c].in_wptr), word_t'(landed[c] % RING_WORDS));
      j = 0;
      for (int k = 0; k < n; k++) begin
        a = ring_addr(c, 1'b0, base[c] + k);
        cpu_access(1'b0, a, '0, 1'b0, rd);
        while (j < strobed[c].size() && strobed[c][j] !== rd) j++;
        if (j == strobed[c].size()) begin
          note_error($sformatf("word %h on channel %0d is out of order or never strobed", rd, c));
        end else begin
          j++;
        end
        model_mem[a]   = rd;
        model_known[a] = 1'b1;
      end
    end
    track_in = 1'b1;
    end_test("overflow", e0);

    // test 5, random mixed traffic below the overflow rate
    e0 = errors;
    for (int step = 0; step < 150; step++) begin
      n = int'((lcg_next() >> 16) % 4);
      j = int'((lcg_next() >> 16) % NUM_CH);
      case (n)
        0: begin
          w = lcg_next();
          ch_write[j] <= 1'b1;
          ch_wdata[j] <= w;
          in_acc[j].push_back(w);
          @(posedge CPU_CLK);
          ch_write[j] <= 1'b0;
          repeat (2) @(posedge CPU_CLK);
        end
        1: if (out_wr[j] - out_rd[j] < RING_WORDS) out_fill(j, 1);
        2: if (out_rd[j] < out_wr[j]) out_drain(j, 1);
        default: begin
          a = lsab_addr_t'(lcg_next() >> 20);
          if (model_known[a] && !slot_pending(a)) cpu_access(1'b0, a, '0, 1'b1, rd);
        end
      endcase
      @(posedge CPU_CLK);
    end
    for (int c = 0; c < NUM_CH; c++) begin
      while (in_acc[c].size() != 0) @(posedge CPU_CLK);
    end
    repeat (4) @(posedge CPU_CLK);
    end_test("random", e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
logic/chip_pkg.sv
logic/lsab_ram.sv
logic/lsab_arbiter.sv
logic/channel_port.sv
logic/cpu_port.sv
logic/chip.sv
tb/clock_gen.sv
tb/chip_sva.sv
tb/chip_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := chip_tb
FILELIST  := list.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -qx "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
